// File: Bender.yml
package:
  name: host_pmu

sources:
  - files:
      - rtl/host_pmu_pkg.sv
      - rtl/pmu_reg_if.sv
      - rtl/event_sync_rx.sv
      - rtl/pmu_cfg_port.sv
      - rtl/pmu_counter_bank.sv
      - rtl/host_pmu_top.sv
  - target: test
    files:
      - test/tb_host_pmu.sv

// File: compile.f
rtl/host_pmu_pkg.sv
rtl/pmu_reg_if.sv
rtl/event_sync_rx.sv
rtl/pmu_cfg_port.sv
rtl/pmu_counter_bank.sv
rtl/host_pmu_top.sv
test/tb_host_pmu.sv

// File: rtl/event_sync_rx.sv
// Receiver side of a four-phase event crossing; instantiate once per cross-domain event
`timescale 1ns/1ns

module event_sync_rx import host_pmu_pkg::*; (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic valid_i,
  output logic ack_o,
  output logic pulse_o
);

  logic [SyncStages-1:0] sync_q;
  logic                  level;
  logic                  level_dly_q;

  // Synchronizer chain where bit 0 samples the foreign request
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[SyncStages-2:0], valid_i};
    end
  end

  assign level = sync_q[SyncStages-1];

  // Previous level for edge detection
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      level_dly_q <= 1'b0;
    end else begin
      level_dly_q <= level;
    end
  end

  // Ack mirrors the synchronized request level
  assign ack_o   = level;
  assign pulse_o = level & ~level_dly_q;

endmodule

// File: rtl/host_pmu_pkg.sv
// Shared widths, register map, event indices and types of the host PMU; import where needed
package host_pmu_pkg;

  // Counter bank geometry
  localparam int unsigned PmuNumCounter = 4;
  localparam int unsigned PmuCntWidth   = 32;
  localparam int unsigned CfgAddrWidth  = 8;
  localparam int unsigned NumEvents     = 5;
  localparam int unsigned EvtSelWidth   = 3;
  localparam int unsigned SyncStages    = 2;

  // Register map in byte offsets
  localparam int unsigned CounterStride = 16;
  localparam int unsigned RegCtrlOff    = 0;
  localparam int unsigned RegCountOff   = 4;
  localparam int unsigned RegThreshOff  = 8;
  localparam int unsigned IrqStatusAddr = 64;

  // Event source index that doubles as the event select code
  typedef enum logic [EvtSelWidth-1:0] {
    EvtLlcReadHit   = 3'd0,
    EvtLlcReadMiss  = 3'd1,
    EvtLlcWriteHit  = 3'd2,
    EvtLlcWriteMiss = 3'd3,
    EvtDmaPe        = 3'd4
  } pmu_event_e;

  typedef logic [CfgAddrWidth-1:0]          cfg_addr_t;
  typedef logic [PmuCntWidth-1:0]           cfg_data_t;
  typedef logic [PmuCntWidth-1:0]           pmu_cnt_t;
  typedef logic [$clog2(PmuNumCounter)-1:0] pmu_idx_t;
  typedef logic [NumEvents-1:0]             pmu_events_t;

  // Enable in bit 3 and event select in bits 2:0
  typedef struct packed {
    logic                   en;
    logic [EvtSelWidth-1:0] evt_sel;
  } pmu_ctrl_t;

  typedef enum logic [1:0] {
    RespOkay   = 2'd0,
    RespSlvErr = 2'd2
  } cfg_resp_e;

endpackage

// File: rtl/host_pmu_top.sv
// Top level of the host performance monitor; plain ports for config, events and interrupt
`timescale 1ns/1ns

module host_pmu_top import host_pmu_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  // Configuration request
  input  logic      cfg_req_valid_i,
  output logic      cfg_req_ready_o,
  input  logic      cfg_req_write_i,
  input  cfg_addr_t cfg_req_addr_i,
  input  cfg_data_t cfg_req_wdata_i,
  // Configuration response
  output logic      cfg_rsp_valid_o,
  input  logic      cfg_rsp_ready_i,
  output cfg_data_t cfg_rsp_rdata_o,
  output cfg_resp_e cfg_rsp_resp_o,
  // LLC event strobes
  input  logic      llc_read_hit_i,
  input  logic      llc_read_miss_i,
  input  logic      llc_write_hit_i,
  input  logic      llc_write_miss_i,
  // Cluster DMA event over a four-phase handshake
  input  logic      dma_pe_evt_valid_i,
  output logic      dma_pe_evt_ack_o,
  output logic      irq_o
);

  logic        dma_pe_evt;
  pmu_events_t events;

  pmu_reg_if i_reg_if ();

  // Pack strobes in event index order
  assign events[EvtLlcReadHit]   = llc_read_hit_i;
  assign events[EvtLlcReadMiss]  = llc_read_miss_i;
  assign events[EvtLlcWriteHit]  = llc_write_hit_i;
  assign events[EvtLlcWriteMiss] = llc_write_miss_i;
  assign events[EvtDmaPe]        = dma_pe_evt;

  event_sync_rx i_dma_pe_evt_rx (
    .clk_i   ( clk_i              ),
    .rst_n_i ( rst_n_i            ),
    .valid_i ( dma_pe_evt_valid_i ),
    .ack_o   ( dma_pe_evt_ack_o   ),
    .pulse_o ( dma_pe_evt         )
  );

  pmu_cfg_port i_cfg_port (
    .clk_i       ( clk_i           ),
    .rst_n_i     ( rst_n_i         ),
    .req_valid_i ( cfg_req_valid_i ),
    .req_ready_o ( cfg_req_ready_o ),
    .req_write_i ( cfg_req_write_i ),
    .req_addr_i  ( cfg_req_addr_i  ),
    .req_wdata_i ( cfg_req_wdata_i ),
    .rsp_valid_o ( cfg_rsp_valid_o ),
    .rsp_ready_i ( cfg_rsp_ready_i ),
    .rsp_rdata_o ( cfg_rsp_rdata_o ),
    .rsp_resp_o  ( cfg_rsp_resp_o  ),
    .reg_o       ( i_reg_if.cfg    )
  );

  pmu_counter_bank i_counter_bank (
    .clk_i    ( clk_i         ),
    .rst_n_i  ( rst_n_i       ),
    .events_i ( events        ),
    .reg_i    ( i_reg_if.bank ),
    .irq_o    ( irq_o         )
  );

endmodule

// File: rtl/pmu_cfg_port.sv
// Valid/ready configuration front end of the PMU; decodes requests and holds one response
`timescale 1ns/1ns

module pmu_cfg_port import host_pmu_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  // Request channel
  input  logic      req_valid_i,
  output logic      req_ready_o,
  input  logic      req_write_i,
  input  cfg_addr_t req_addr_i,
  input  cfg_data_t req_wdata_i,
  // Response channel
  output logic      rsp_valid_o,
  input  logic      rsp_ready_i,
  output cfg_data_t rsp_rdata_o,
  output cfg_resp_e rsp_resp_o,
  // Towards the counter bank
  pmu_reg_if.cfg    reg_o
);

  logic      aligned;
  logic      cnt_hit;
  logic      sts_hit;
  logic      acc_ok;
  logic      xfer;
  cfg_addr_t blk_off;
  cfg_addr_t blk_idx;

  logic      rsp_valid_q;
  cfg_data_t rsp_rdata_q;
  cfg_resp_e rsp_resp_q;

  // Address decode
  assign aligned = (req_addr_i[1:0] == 2'b00);
  assign blk_off = cfg_addr_t'(req_addr_i % CounterStride);
  assign blk_idx = cfg_addr_t'(req_addr_i / CounterStride);

  // Offset 12 of a counter block stays unmapped
  assign cnt_hit = aligned && (req_addr_i < IrqStatusAddr) &&
                   ((blk_off == RegCtrlOff) || (blk_off == RegCountOff) ||
                    (blk_off == RegThreshOff));
  assign sts_hit = (req_addr_i == IrqStatusAddr);
  assign acc_ok  = cnt_hit || sts_hit;

  // Only one access outstanding
  assign req_ready_o = ~rsp_valid_q;
  assign xfer        = req_valid_i & req_ready_o;

  // Strobes only for mapped, aligned accesses
  assign reg_o.wr_en   = xfer & req_write_i & acc_ok;
  assign reg_o.rd_en   = xfer & ~req_write_i & acc_ok;
  assign reg_o.cnt_idx = blk_idx[$bits(pmu_idx_t)-1:0];
  assign reg_o.reg_off = blk_off;
  assign reg_o.sts_sel = sts_hit;
  assign reg_o.wdata   = req_wdata_i;

  // Response held until accepted
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_valid_q <= 1'b0;
      rsp_rdata_q <= '0;
      rsp_resp_q  <= RespOkay;
    end else if (xfer) begin
      rsp_valid_q <= 1'b1;
      // Writes and errors answer with zero data
      rsp_rdata_q <= reg_o.rd_en ? reg_o.rdata : '0;
      rsp_resp_q  <= acc_ok ? RespOkay : RespSlvErr;
    end else if (rsp_ready_i) begin
      rsp_valid_q <= 1'b0;
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_rdata_o = rsp_rdata_q;
  assign rsp_resp_o  = rsp_resp_q;

endmodule

// File: rtl/pmu_counter_bank.sv
// Programmable event counters with thresholds and a shared interrupt; driven by pmu_cfg_port
`timescale 1ns/1ns

module pmu_counter_bank import host_pmu_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  pmu_events_t events_i,
  pmu_reg_if.bank     reg_i,
  output logic        irq_o
);

  pmu_ctrl_t                ctrl_q   [PmuNumCounter];
  pmu_cnt_t                 cnt_q    [PmuNumCounter];
  pmu_cnt_t                 thresh_q [PmuNumCounter];
  logic [PmuNumCounter-1:0] status_q;
  logic [PmuNumCounter-1:0] status_d;
  logic                     irq_q;

  logic [2**EvtSelWidth-1:0] evt_all;
  logic [PmuNumCounter-1:0]  inc_en;
  logic [PmuNumCounter-1:0]  thr_hit;
  logic [PmuNumCounter-1:0]  wr_ctrl;
  logic [PmuNumCounter-1:0]  wr_cnt;
  logic [PmuNumCounter-1:0]  wr_thr;
  logic [PmuNumCounter-1:0]  sts_clr;
  pmu_cnt_t                  cnt_inc  [PmuNumCounter];

  // Select codes 5 to 7 see constant zero
  assign evt_all = {{(2**EvtSelWidth-NumEvents){1'b0}}, events_i};

  always_comb begin
    for (int i = 0; i < PmuNumCounter; i++) begin
      wr_ctrl[i] = reg_i.wr_en && !reg_i.sts_sel && (reg_i.cnt_idx == pmu_idx_t'(i)) &&
                   (reg_i.reg_off == RegCtrlOff);
      wr_cnt[i]  = reg_i.wr_en && !reg_i.sts_sel && (reg_i.cnt_idx == pmu_idx_t'(i)) &&
                   (reg_i.reg_off == RegCountOff);
      wr_thr[i]  = reg_i.wr_en && !reg_i.sts_sel && (reg_i.cnt_idx == pmu_idx_t'(i)) &&
                   (reg_i.reg_off == RegThreshOff);
      inc_en[i]  = ctrl_q[i].en & evt_all[ctrl_q[i].evt_sel];
      cnt_inc[i] = cnt_q[i] + 1'b1;
      // Threshold match only on a real increment
      thr_hit[i] = inc_en[i] && !wr_cnt[i] && (thresh_q[i] != '0) &&
                   (cnt_inc[i] == thresh_q[i]);
    end
  end

  // Write one to clear but a new hit in the same cycle wins
  assign sts_clr  = (reg_i.wr_en && reg_i.sts_sel) ? reg_i.wdata[PmuNumCounter-1:0] : '0;
  assign status_d = (status_q & ~sts_clr) | thr_hit;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < PmuNumCounter; i++) begin
        ctrl_q[i]   <= '0;
        cnt_q[i]    <= '0;
        thresh_q[i] <= '0;
      end
      status_q <= '0;
      irq_q    <= 1'b0;
    end else begin
      for (int i = 0; i < PmuNumCounter; i++) begin
        if (wr_ctrl[i]) begin
          ctrl_q[i] <= pmu_ctrl_t'(reg_i.wdata[$bits(pmu_ctrl_t)-1:0]);
        end
        if (wr_thr[i]) begin
          thresh_q[i] <= reg_i.wdata;
        end
        // Software write beats the increment
        if (wr_cnt[i]) begin
          cnt_q[i] <= reg_i.wdata;
        end else if (inc_en[i]) begin
          cnt_q[i] <= cnt_inc[i];
        end
      end
      status_q <= status_d;
      irq_q    <= |status_d;
    end
  end

  assign irq_o = irq_q;

  // Read mux
  always_comb begin
    reg_i.rdata = '0;
    if (reg_i.rd_en) begin
      if (reg_i.sts_sel) begin
        reg_i.rdata = cfg_data_t'(status_q);
      end else begin
        case (reg_i.reg_off)
          RegCtrlOff:   reg_i.rdata = cfg_data_t'(ctrl_q[reg_i.cnt_idx]);
          RegCountOff:  reg_i.rdata = cnt_q[reg_i.cnt_idx];
          RegThreshOff: reg_i.rdata = thresh_q[reg_i.cnt_idx];
          default:      reg_i.rdata = '0;
        endcase
      end
    end
  end

endmodule

// File: rtl/pmu_reg_if.sv
// Register access channel between the configuration front end and the counter bank
`timescale 1ns/1ns

interface pmu_reg_if import host_pmu_pkg::*; ();

  logic      wr_en;
  logic      rd_en;
  // Counter block target that sts_sel overrides
  pmu_idx_t  cnt_idx;
  cfg_addr_t reg_off;
  // Interrupt status register
  logic      sts_sel;
  cfg_data_t wdata;
  cfg_data_t rdata;

  modport cfg (
    output wr_en, rd_en, cnt_idx, reg_off, sts_sel, wdata,
    input  rdata
  );

  modport bank (
    input  wr_en, rd_en, cnt_idx, reg_off, sts_sel, wdata,
    output rdata
  );

endinterface

// File: test/tb_host_pmu.sv
// Directed testbench for the host PMU top level; simulate with tb_host_pmu as top module
`timescale 1ns/1ns

module tb_host_pmu import host_pmu_pkg::*; ();

  localparam int Timeout = 100;

  logic       clk;
  logic       rst_n;
  logic       cfg_req_valid;
  logic       cfg_req_ready;
  logic       cfg_req_write;
  cfg_addr_t  cfg_req_addr;
  cfg_data_t  cfg_req_wdata;
  logic       cfg_rsp_valid;
  logic       cfg_rsp_ready;
  cfg_data_t  cfg_rsp_rdata;
  cfg_resp_e  cfg_rsp_resp;
  // Read hit, read miss, write hit, write miss
  logic [3:0] llc_evt;
  logic       dma_valid;
  logic       dma_ack;
  logic       irq;
  integer     seed;
  int         errors;
  int         checks;

  host_pmu_top i_dut (
    .clk_i              ( clk           ),
    .rst_n_i            ( rst_n         ),
    .cfg_req_valid_i    ( cfg_req_valid ),
    .cfg_req_ready_o    ( cfg_req_ready ),
    .cfg_req_write_i    ( cfg_req_write ),
    .cfg_req_addr_i     ( cfg_req_addr  ),
    .cfg_req_wdata_i    ( cfg_req_wdata ),
    .cfg_rsp_valid_o    ( cfg_rsp_valid ),
    .cfg_rsp_ready_i    ( cfg_rsp_ready ),
    .cfg_rsp_rdata_o    ( cfg_rsp_rdata ),
    .cfg_rsp_resp_o     ( cfg_rsp_resp  ),
    .llc_read_hit_i     ( llc_evt[0]    ),
    .llc_read_miss_i    ( llc_evt[1]    ),
    .llc_write_hit_i    ( llc_evt[2]    ),
    .llc_write_miss_i   ( llc_evt[3]    ),
    .dma_pe_evt_valid_i ( dma_valid     ),
    .dma_pe_evt_ack_o   ( dma_ack       ),
    .irq_o              ( irq           )
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic check(input string name, input logic [31:0] actual,
                       input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("MISMATCH at %0t ns: %s is 0x%08h, expected 0x%08h",
               $time, name, actual, expected);
    end
  endtask

  // Byte address of a register inside a counter block
  function automatic cfg_addr_t reg_addr(input int idx, input int off);
    return cfg_addr_t'(idx * CounterStride + off);
  endfunction

  // One request and response handshake
  task automatic cfg_access(input logic write, input cfg_addr_t addr, input cfg_data_t wdata,
                            output cfg_data_t rdata, output cfg_resp_e resp);
    int n;
    @(posedge clk);
    cfg_req_valid <= 1'b1;
    cfg_req_write <= write;
    cfg_req_addr  <= addr;
    cfg_req_wdata <= wdata;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!cfg_req_ready && n < Timeout);
    if (!cfg_req_ready) begin
      errors++;
      $display("Request to address 0x%02h was not accepted in time", addr);
    end
    @(posedge clk);
    cfg_req_valid <= 1'b0;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!cfg_rsp_valid && n < Timeout);
    if (!cfg_rsp_valid) begin
      errors++;
      $display("No response arrived for address 0x%02h", addr);
    end
    rdata = cfg_rsp_rdata;
    resp  = cfg_rsp_resp;
  endtask

  task automatic cfg_write(input cfg_addr_t addr, input cfg_data_t wdata,
                           input cfg_resp_e exp_resp);
    cfg_data_t rdata;
    cfg_resp_e resp;
    cfg_access(1'b1, addr, wdata, rdata, resp);
    check($sformatf("cfg_rsp_resp_o @0x%02h", addr), resp, exp_resp);
    check($sformatf("cfg_rsp_rdata_o @0x%02h", addr), rdata, '0);
  endtask

  task automatic cfg_read(input cfg_addr_t addr, input cfg_data_t exp_data,
                          input cfg_resp_e exp_resp);
    cfg_data_t rdata;
    cfg_resp_e resp;
    cfg_access(1'b0, addr, '0, rdata, resp);
    check($sformatf("cfg_rsp_resp_o @0x%02h", addr), resp, exp_resp);
    check($sformatf("cfg_rsp_rdata_o @0x%02h", addr), rdata, exp_data);
  endtask

  task automatic wait_ack(input logic level);
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (dma_ack !== level && n < Timeout);
    if (dma_ack !== level) begin
      errors++;
      $display("DMA event ack did not go to %0b in time", level);
    end
  endtask

  // Four-phase handshake from the sender side
  task automatic dma_event();
    @(posedge clk);
    dma_valid <= 1'b1;
    wait_ack(1'b1);
    @(posedge clk);
    dma_valid <= 1'b0;
    wait_ack(1'b0);
  endtask

  task automatic reset_defaults();
    @(negedge clk);
    check("irq_o", irq, 0);
    check("cfg_rsp_valid_o", cfg_rsp_valid, 0);
    check("dma_pe_evt_ack_o", dma_ack, 0);
    check("cfg_req_ready_o", cfg_req_ready, 1);
    for (int i = 0; i < PmuNumCounter; i++) begin
      cfg_read(reg_addr(i, RegCtrlOff), '0, RespOkay);
      cfg_read(reg_addr(i, RegCountOff), '0, RespOkay);
      cfg_read(reg_addr(i, RegThreshOff), '0, RespOkay);
    end
    cfg_read(IrqStatusAddr, '0, RespOkay);
  endtask

  task automatic register_readback();
    cfg_write(reg_addr(1, RegThreshOff), 32'hA5A5_1234, RespOkay);
    cfg_write(reg_addr(2, RegCountOff), 32'hDEAD_BEEF, RespOkay);
    cfg_write(reg_addr(0, RegCtrlOff), 32'hFFFF_FFF5, RespOkay);
    cfg_read(reg_addr(1, RegThreshOff), 32'hA5A5_1234, RespOkay);
    cfg_read(reg_addr(2, RegCountOff), 32'hDEAD_BEEF, RespOkay);
    cfg_read(reg_addr(0, RegCtrlOff), 32'h5, RespOkay);
    // Unmapped and misaligned accesses
    cfg_read(reg_addr(1, 12), '0, RespSlvErr);
    cfg_read(reg_addr(1, RegThreshOff + 1), '0, RespSlvErr);
    cfg_write(reg_addr(1, RegThreshOff + 2), 32'h1, RespSlvErr);
    cfg_write(reg_addr(1, 12), 32'h1, RespSlvErr);
    cfg_read(reg_addr(1, RegThreshOff), 32'hA5A5_1234, RespOkay);
  endtask

  task automatic cache_counting();
    int         expected [4];
    logic [3:0] pattern;
    for (int i = 0; i < 4; i++) begin
      cfg_write(reg_addr(i, RegCountOff), '0, RespOkay);
      cfg_write(reg_addr(i, RegCtrlOff), 32'h8 | i, RespOkay);
      expected[i] = 0;
    end
    for (int c = 0; c < 200; c++) begin
      @(posedge clk);
      pattern = $random(seed);
      llc_evt <= pattern;
      for (int i = 0; i < 4; i++) begin
        expected[i] += pattern[i];
      end
    end
    @(posedge clk);
    llc_evt <= '0;
    for (int i = 0; i < 4; i++) begin
      cfg_read(reg_addr(i, RegCountOff), expected[i], RespOkay);
    end
    // Disabled counter 3 holds its count
    cfg_write(reg_addr(3, RegCtrlOff), 32'h3, RespOkay);
    for (int c = 0; c < 50; c++) begin
      @(posedge clk);
      llc_evt <= $random(seed);
    end
    @(posedge clk);
    llc_evt <= '0;
    cfg_read(reg_addr(3, RegCountOff), expected[3], RespOkay);
  endtask

  task automatic dma_crossing();
    cfg_write(reg_addr(0, RegCountOff), '0, RespOkay);
    cfg_write(reg_addr(0, RegCtrlOff), 32'h8 | EvtDmaPe, RespOkay);
    repeat (7) dma_event();
    cfg_read(reg_addr(0, RegCountOff), 32'd7, RespOkay);
  endtask

  task automatic threshold_interrupt();
    cfg_write(reg_addr(1, RegCtrlOff), 32'h8 | EvtLlcReadHit, RespOkay);
    cfg_write(reg_addr(1, RegCountOff), '0, RespOkay);
    cfg_write(reg_addr(1, RegThreshOff), 32'd3, RespOkay);
    for (int p = 1; p <= 3; p++) begin
      @(posedge clk);
      llc_evt <= 4'b0001;
      @(posedge clk);
      llc_evt <= 4'b0000;
      @(negedge clk);
      check($sformatf("irq_o after %0d pulses", p), irq, p == 3);
    end
    cfg_read(IrqStatusAddr, 32'h2, RespOkay);
    cfg_write(IrqStatusAddr, 32'h2, RespOkay);
    check("irq_o after clear", irq, 0);
    cfg_read(IrqStatusAddr, '0, RespOkay);
  endtask

  task automatic response_back_pressure();
    cfg_data_t held;
    cfg_resp_e resp;
    @(posedge clk);
    cfg_rsp_ready <= 1'b0;
    cfg_access(1'b0, reg_addr(1, RegCountOff), '0, held, resp);
    check("cfg_rsp_rdata_o", held, 32'd3);
    check("cfg_rsp_resp_o", resp, RespOkay);
    for (int c = 0; c < 10; c++) begin
      @(negedge clk);
      check("cfg_rsp_valid_o", cfg_rsp_valid, 1);
      check("cfg_rsp_rdata_o", cfg_rsp_rdata, 32'd3);
      check("cfg_req_ready_o", cfg_req_ready, 0);
    end
    @(posedge clk);
    cfg_rsp_ready <= 1'b1;
    @(posedge clk);
    @(negedge clk);
    check("cfg_rsp_valid_o", cfg_rsp_valid, 0);
    check("cfg_req_ready_o", cfg_req_ready, 1);
  endtask

  initial begin
    seed          = 11675;
    errors        = 0;
    checks        = 0;
    rst_n         = 1'b0;
    cfg_req_valid = 1'b0;
    cfg_req_write = 1'b0;
    cfg_req_addr  = '0;
    cfg_req_wdata = '0;
    cfg_rsp_ready = 1'b1;
    llc_evt       = '0;
    dma_valid     = 1'b0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    reset_defaults();
    register_readback();
    cache_counting();
    dma_crossing();
    threshold_interrupt();
    response_back_pressure();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule
